//--- bridge_pkg.sv
//----------------------------------------------------------
// Shared widths, data types and FSM state encodings
// for the bus bridge slave
//----------------------------------------------------------

package bridge_pkg;

    // Bus and frame widths
    localparam int ADDR_W  = 12;                  // Serial bus address
    localparam int DATA_W  = 8;                   // Data byte
    localparam int MEM_AW  = ADDR_W - 1;          // Local half of the map
    localparam int FRAME_W = 1 + DATA_W + ADDR_W; // Mode, data, address

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [MEM_AW-1:0]  mem_addr_t;
    typedef logic [FRAME_W-1:0] frame_t;          // {mode, data, addr}

    //------------------------------------------------------
    // State encodings
    //------------------------------------------------------
    typedef enum logic [2:0] {
        P_IDLE,   // sready high, waiting for first mvalid bit
        P_ADDR,   // Shifting in address
        P_WDATA,  // Shifting in write data
        P_WAIT,   // Request issued, waiting for done
        P_RESP    // Shifting read data out
    } port_state_e;

    typedef enum logic [2:0] {
        C_IDLE,
        C_LOCAL,  // One memory cycle
        C_SEND,   // Frame handed to UART TX
        C_TXWAIT, // Frame on the wire
        C_RXWAIT  // Remote read, waiting for reply byte
    } ctrl_state_e;

    // Shared by UART TX and RX
    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_state_e;

endpackage

//--- serial_slave_port.sv
//----------------------------------------------------------
// Serial bus slave port: shifts in address and write data,
// issues one request, shifts read data back out
//----------------------------------------------------------

module serial_slave_port (
    input  logic              clk,
    input  logic              rstn,
    input  logic              swdata,    // Address/data bit from master, LSB first
    input  logic              smode,     // 1 write, 0 read
    input  logic              mvalid,
    input  logic              done,      // Controller finished the request
    input  bridge_pkg::data_t rdata,     // Valid with done on reads
    output logic              srdata,
    output logic              svalid,
    output logic              sready,
    output logic              req,       // One-cycle request pulse
    output logic              req_write,
    output bridge_pkg::addr_t req_addr,
    output bridge_pkg::data_t req_wdata
);

    localparam int               CNT_W     = $clog2(bridge_pkg::ADDR_W);
    localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(bridge_pkg::ADDR_W - 1);
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(bridge_pkg::DATA_W - 1);

    bridge_pkg::port_state_e state;
    logic [CNT_W-1:0]        cnt;     // Bit index within current phase
    bridge_pkg::data_t       rshift;  // Read data on its way out
    logic                    start;   // First mvalid bit of a request

    assign sready = (state == bridge_pkg::P_IDLE);
    assign svalid = (state == bridge_pkg::P_RESP);
    assign srdata = svalid & rshift[0];
    assign start  = sready & mvalid;  // Requests while busy are ignored

    //------------------------------------------------------
    // Control FSM
    //------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= bridge_pkg::P_IDLE;
            cnt   <= '0;
            req   <= 1'b0;
        end else begin
            req <= 1'b0;
            case (state)
                bridge_pkg::P_IDLE: begin
                    if (start) begin
                        cnt   <= CNT_W'(1);  // Bit 0 taken this cycle
                        state <= bridge_pkg::P_ADDR;
                    end
                end
                bridge_pkg::P_ADDR: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ADDR_LAST) begin
                        cnt <= '0;
                        if (req_write) begin
                            state <= bridge_pkg::P_WDATA;
                        end else begin
                            req   <= 1'b1;  // Read needs no data phase
                            state <= bridge_pkg::P_WAIT;
                        end
                    end
                end
                bridge_pkg::P_WDATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DATA_LAST) begin
                        cnt   <= '0;
                        req   <= 1'b1;
                        state <= bridge_pkg::P_WAIT;
                    end
                end
                bridge_pkg::P_WAIT: begin
                    if (done) begin
                        state <= req_write ? bridge_pkg::P_IDLE : bridge_pkg::P_RESP;
                    end
                end
                bridge_pkg::P_RESP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DATA_LAST) begin
                        cnt   <= '0;
                        state <= bridge_pkg::P_IDLE;  // sready back next cycle
                    end
                end
                default: state <= bridge_pkg::P_IDLE;
            endcase
        end
    end

    //------------------------------------------------------
    // Payload shift registers
    //------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start)
            req_write <= smode;  // Mode sampled on first bit only
        if (start || state == bridge_pkg::P_ADDR)
            req_addr <= {swdata, req_addr[bridge_pkg::ADDR_W-1:1]};
        if (state == bridge_pkg::P_WDATA)
            req_wdata <= {swdata, req_wdata[bridge_pkg::DATA_W-1:1]};
        if (state == bridge_pkg::P_WAIT && done)
            rshift <= rdata;
        else if (svalid)
            rshift <= rshift >> 1;  // LSB leaves first
    end

endmodule

//--- local_mem.sv
//----------------------------------------------------------
// Local memory, 2048 bytes, registered read
//----------------------------------------------------------

module local_mem (
    input  logic                  clk,
    input  logic                  mem_wen,
    input  logic                  mem_ren,
    input  bridge_pkg::mem_addr_t mem_addr,
    input  bridge_pkg::data_t     mem_wdata,
    output bridge_pkg::data_t     mem_rdata   // Valid the cycle after mem_ren
);

    bridge_pkg::data_t mem [0:(1 << bridge_pkg::MEM_AW)-1];

    always_ff @(posedge clk) begin
        if (mem_wen)
            mem[mem_addr] <= mem_wdata;
        if (mem_ren)
            mem_rdata <= mem[mem_addr];  // Holds last read otherwise
    end

endmodule

//--- uart_tx.sv
//----------------------------------------------------------
// UART transmitter for 21-bit request frames
// Start bit, payload LSB first, stop bit
//----------------------------------------------------------

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tx_start,  // One-cycle pulse with tx_frame
    input  bridge_pkg::frame_t tx_frame,
    output logic               u_tx,
    output logic               tx_busy,
    output logic               tx_done    // Pulses as tx_busy falls
);

    localparam int                BAUD_W    = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
    localparam int                BIT_W     = $clog2(bridge_pkg::FRAME_W);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(bridge_pkg::FRAME_W - 1);

    bridge_pkg::uart_state_e state;
    logic [BAUD_W-1:0]       baud;
    logic [BIT_W-1:0]        bit_cnt;
    bridge_pkg::frame_t      shreg;
    logic                    bit_end;

    assign tx_busy = (state != bridge_pkg::U_IDLE);
    assign bit_end = (baud == BAUD_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= bridge_pkg::U_IDLE;
            baud    <= '0;
            bit_cnt <= '0;
            u_tx    <= 1'b1;  // Line idles high
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            baud    <= (!tx_busy || bit_end) ? '0 : baud + 1'b1;
            case (state)
                bridge_pkg::U_IDLE: begin
                    if (tx_start) begin
                        u_tx  <= 1'b0;  // Start bit
                        state <= bridge_pkg::U_START;
                    end
                end
                bridge_pkg::U_START: begin
                    if (bit_end) begin
                        u_tx    <= shreg[0];
                        bit_cnt <= '0;
                        state   <= bridge_pkg::U_DATA;
                    end
                end
                bridge_pkg::U_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        u_tx    <= shreg[1];  // Next bit after this shift
                        if (bit_cnt == BIT_LAST) begin
                            u_tx  <= 1'b1;    // Stop bit
                            state <= bridge_pkg::U_STOP;
                        end
                    end
                end
                bridge_pkg::U_STOP: begin
                    if (bit_end) begin
                        tx_done <= 1'b1;
                        state   <= bridge_pkg::U_IDLE;
                    end
                end
                default: state <= bridge_pkg::U_IDLE;
            endcase
        end
    end

    // Frame shifter
    always_ff @(posedge clk) begin
        if (state == bridge_pkg::U_IDLE && tx_start)
            shreg <= tx_frame;
        else if (state == bridge_pkg::U_DATA && bit_end)
            shreg <= shreg >> 1;
    end

endmodule

//--- uart_rx.sv
//----------------------------------------------------------
// UART receiver for one-byte reply frames
// Mid-bit sampling, valid pulse in middle of stop bit
//----------------------------------------------------------

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              u_rx,
    output logic              rx_valid,  // One cycle, good stop bit only
    output bridge_pkg::data_t rx_data
);

    localparam int                BAUD_W    = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(CLKS_PER_BIT / 2 - 1);
    localparam int                BIT_W     = $clog2(bridge_pkg::DATA_W);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(bridge_pkg::DATA_W - 1);

    bridge_pkg::uart_state_e state;
    logic [BAUD_W-1:0]       baud;
    logic [BIT_W-1:0]        bit_cnt;
    logic                    rx_s1, rx_s2;  // Synchronizer
    logic                    rx_d;          // Previous synced value
    logic                    bit_end;

    assign bit_end = (baud == BAUD_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            {rx_s1, rx_s2, rx_d} <= 3'b111;
            state    <= bridge_pkg::U_IDLE;
            baud     <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            {rx_s1, rx_s2, rx_d} <= {u_rx, rx_s1, rx_s2};
            rx_valid <= 1'b0;
            baud     <= (state == bridge_pkg::U_IDLE || bit_end) ? '0 : baud + 1'b1;
            case (state)
                bridge_pkg::U_IDLE: begin
                    if (rx_d && !rx_s2)  // Falling edge, start bit begins
                        state <= bridge_pkg::U_START;
                end
                bridge_pkg::U_START: begin
                    if (baud == BAUD_HALF) begin
                        baud    <= '0;   // Realign to bit centres
                        bit_cnt <= '0;
                        state   <= rx_s2 ? bridge_pkg::U_IDLE : bridge_pkg::U_DATA;
                    end
                end
                bridge_pkg::U_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                            state <= bridge_pkg::U_STOP;
                    end
                end
                bridge_pkg::U_STOP: begin
                    if (bit_end) begin
                        rx_valid <= rx_s2;  // Framing error drops the byte
                        state    <= bridge_pkg::U_IDLE;
                    end
                end
                default: state <= bridge_pkg::U_IDLE;
            endcase
        end
    end

    // Data shifter, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == bridge_pkg::U_DATA && bit_end)
            rx_data <= {rx_s2, rx_data[bridge_pkg::DATA_W-1:1]};
    end

endmodule

//--- bridge_ctrl.sv
//----------------------------------------------------------
// Request controller: address decode, local memory access
// or remote access over UART
//----------------------------------------------------------

module bridge_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req,
    input  logic                  req_write,
    input  bridge_pkg::addr_t     req_addr,   // Stable from req to done
    input  bridge_pkg::data_t     req_wdata,
    input  bridge_pkg::data_t     mem_rdata,
    input  logic                  tx_done,
    input  logic                  rx_valid,
    input  bridge_pkg::data_t     rx_data,
    output logic                  done,
    output bridge_pkg::data_t     rdata,
    output logic                  mem_wen,
    output logic                  mem_ren,
    output bridge_pkg::mem_addr_t mem_addr,
    output bridge_pkg::data_t     mem_wdata,
    output logic                  tx_start,
    output bridge_pkg::frame_t    tx_frame
);

    bridge_pkg::ctrl_state_e state;
    bridge_pkg::data_t       rx_byte;    // Reply held for done
    logic                    is_remote;

    // Upper half of the map lives on the remote side
    assign is_remote = req_addr[bridge_pkg::ADDR_W-1];

    //------------------------------------------------------
    // Memory and UART strobes, one cycle from state
    //------------------------------------------------------
    assign mem_wen   = (state == bridge_pkg::C_LOCAL) &  req_write;
    assign mem_ren   = (state == bridge_pkg::C_LOCAL) & ~req_write;
    assign mem_addr  = req_addr[bridge_pkg::MEM_AW-1:0];
    assign mem_wdata = req_wdata;

    assign tx_start  = (state == bridge_pkg::C_SEND);
    // Read requests carry a zero data field
    assign tx_frame  = {req_write, req_wdata & {bridge_pkg::DATA_W{req_write}}, req_addr};

    // Memory data arrives with done for local reads
    assign rdata = is_remote ? rx_byte : mem_rdata;

    //------------------------------------------------------
    // Sequencer
    //------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= bridge_pkg::C_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                bridge_pkg::C_IDLE: begin
                    if (req)
                        state <= is_remote ? bridge_pkg::C_SEND : bridge_pkg::C_LOCAL;
                end
                bridge_pkg::C_LOCAL: begin
                    done  <= 1'b1;  // Read data lands next cycle
                    state <= bridge_pkg::C_IDLE;
                end
                bridge_pkg::C_SEND: state <= bridge_pkg::C_TXWAIT;
                bridge_pkg::C_TXWAIT: begin
                    if (tx_done) begin
                        if (req_write) begin
                            done  <= 1'b1;  // Remote write is fire and forget
                            state <= bridge_pkg::C_IDLE;
                        end else begin
                            state <= bridge_pkg::C_RXWAIT;
                        end
                    end
                end
                bridge_pkg::C_RXWAIT: begin
                    if (rx_valid) begin
                        done  <= 1'b1;
                        state <= bridge_pkg::C_IDLE;
                    end
                end
                default: state <= bridge_pkg::C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bridge_pkg::C_RXWAIT && rx_valid)
            rx_byte <= rx_data;
    end

endmodule

//--- bus_bridge_slave.sv
//----------------------------------------------------------
// Bus bridge slave top: serial port, controller,
// local memory, UART transmitter and receiver
//----------------------------------------------------------

module bus_bridge_slave #(
    parameter int CLKS_PER_BIT = 16  // UART bit time in clk cycles, 4 or more
) (
    input  logic clk,
    input  logic rstn,
    input  logic swdata,
    input  logic smode,
    input  logic mvalid,
    input  logic u_rx,    // Reply line from remote
    output logic srdata,
    output logic svalid,
    output logic sready,
    output logic u_tx     // Request line to remote
);

    // Port to controller
    logic                  req, req_write, done;
    bridge_pkg::addr_t     req_addr;
    bridge_pkg::data_t     req_wdata, rdata;
    // Controller to memory
    logic                  mem_wen, mem_ren;
    bridge_pkg::mem_addr_t mem_addr;
    bridge_pkg::data_t     mem_wdata, mem_rdata;
    // Controller to UART
    logic                  tx_start, tx_done, rx_valid;
    bridge_pkg::frame_t    tx_frame;
    bridge_pkg::data_t     rx_data;

    serial_slave_port u_port (
        .clk, .rstn, .swdata, .smode, .mvalid, .done, .rdata,
        .srdata, .svalid, .sready, .req, .req_write, .req_addr, .req_wdata
    );

    bridge_ctrl u_ctrl (
        .clk, .rstn, .req, .req_write, .req_addr, .req_wdata,
        .mem_rdata, .tx_done, .rx_valid, .rx_data,
        .done, .rdata, .mem_wen, .mem_ren, .mem_addr, .mem_wdata,
        .tx_start, .tx_frame
    );

    local_mem u_mem (
        .clk, .mem_wen, .mem_ren, .mem_addr, .mem_wdata, .mem_rdata
    );

    // UART links to and from the remote system
    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk, .rstn, .tx_start, .tx_frame,
        .u_tx,
        .tx_busy (),  // Controller paces on tx_done
        .tx_done
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk, .rstn, .u_rx, .rx_valid, .rx_data
    );

endmodule

//--- tb_bus_bridge_slave.sv
//----------------------------------------------------------
// Testbench for the bus bridge slave: serial bus master,
// local and remote models, remote UART decoder and encoder
//----------------------------------------------------------

module tb_bus_bridge_slave;

    localparam int CLKS_PER_BIT = 16;
    localparam int N_RANDOM     = 200;      // Random mix length
    localparam int MAX_CYCLES   = 200_000;  // Room for 200 transactions of about 700 cycles

    logic clk, rstn, swdata, smode, mvalid, u_rx;
    logic srdata, svalid, sready, u_tx;

    bridge_pkg::data_t     local_model  [0:2047];
    logic                  local_valid  [0:2047];  // Word written at least once
    bridge_pkg::data_t     remote_model [0:2047];  // Upper half of the map
    bridge_pkg::mem_addr_t written_q [$];          // Local addresses safe to read

    int errors, checks, cycles;

    bus_bridge_slave #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
        .clk, .rstn, .swdata, .smode, .mvalid, .u_rx,
        .srdata, .svalid, .sready, .u_tx
    );

    always #4 clk = ~clk;  // Period 8

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: transactions did not complete");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    //------------------------------------------------------
    // Bus master side
    //------------------------------------------------------
    task automatic wait_ready();
        @(negedge clk);
        while (sready !== 1'b1)
            @(negedge clk);
    endtask

    // Returns at the falling edge of cycle L+1
    task automatic send_request(input logic write, input bridge_pkg::addr_t addr,
                                input bridge_pkg::data_t data);
        int i;
        wait_ready();
        for (i = 0; i < bridge_pkg::ADDR_W; i++) begin
            if (i > 0)
                @(negedge clk);
            if (i == 1)
                check(32'(sready), 32'd0, "sready low after first request bit");
            mvalid = 1'b1;
            smode  = (i == 0) ? write : ~write;  // Later bits must not change the mode
            swdata = addr[i];  // LSB first
        end
        if (write) begin
            for (i = 0; i < bridge_pkg::DATA_W; i++) begin
                @(negedge clk);
                swdata = data[i];
            end
        end
        @(negedge clk);
        mvalid = 1'b0;
        swdata = 1'b0;
        smode  = 1'b0;
    endtask

    task automatic finish_write(input logic is_local);
        int lat;
        lat = 1;
        while (sready !== 1'b1) begin
            if (is_local)
                check(32'(u_tx), 32'd1, "u_tx idle during local access");
            @(negedge clk);
            lat++;
        end
        if (is_local)
            check(32'(lat), 32'd4, "local write sready return cycle");
    endtask

    task automatic collect_read(input logic is_local, output bridge_pkg::data_t got);
        int lat, i;
        lat = 1;
        while (svalid !== 1'b1) begin
            check(32'(sready), 32'd0, "sready low while read pending");
            if (is_local)
                check(32'(u_tx), 32'd1, "u_tx idle during local access");
            @(negedge clk);
            lat++;
        end
        if (is_local)
            check(32'(lat), 32'd4, "local read first svalid cycle");
        for (i = 0; i < bridge_pkg::DATA_W; i++) begin
            check(32'(svalid), 32'd1, "svalid held for a full byte");
            if (is_local)
                check(32'(u_tx), 32'd1, "u_tx idle during local access");
            got[i] = srdata;
            @(negedge clk);
        end
        check(32'(svalid), 32'd0, "svalid low after read data");
        check(32'(sready), 32'd1, "sready back after read data");
    endtask

    //------------------------------------------------------
    // Remote system side
    //------------------------------------------------------
    // Drives start and data bits and leaves the line high for stop bit and idle
    task automatic send_reply(input bridge_pkg::data_t b);
        logic [8:0] bits;
        int         i;
        bits = {b, 1'b0};
        for (i = 0; i < 9; i++) begin
            u_rx = bits[i];
            repeat (CLKS_PER_BIT) begin
                @(negedge clk);
                check(32'(sready), 32'd0, "sready low during reply");
            end
        end
        u_rx = 1'b1;
    endtask

    task automatic serve_remote(input logic write, input bridge_pkg::addr_t addr,
                                input bridge_pkg::data_t data);
        bridge_pkg::frame_t frame;
        int                 i, gap;
        while (u_tx !== 1'b0)
            @(negedge clk);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Centre of start bit
        check(32'(u_tx), 32'd0, "request start bit");
        for (i = 0; i < bridge_pkg::FRAME_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            frame[i] = u_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check(32'(u_tx), 32'd1, "request stop bit");
        // Frame is {mode, data, addr}
        check(32'(frame[20]), 32'(write), "frame mode bit");
        check(32'(frame[19:12]), 32'(write ? data : 8'h00), "frame data field");
        check(32'(frame[11:0]), 32'(addr), "frame address field");
        if (write) begin
            remote_model[addr[10:0]] = data;
        end else begin
            gap = int'($urandom_range(64, 0));
            repeat (CLKS_PER_BIT / 2 + gap) begin  // Rest of stop bit, then gap
                @(negedge clk);
                check(32'(sready), 32'd0, "sready low before reply");
            end
            send_reply(remote_model[addr[10:0]]);
        end
    endtask

    //------------------------------------------------------
    // One full transaction against the models
    //------------------------------------------------------
    task automatic do_transaction(input logic write, input bridge_pkg::addr_t addr,
                                  input bridge_pkg::data_t data);
        bridge_pkg::data_t got;
        logic              remote;
        remote = addr[11];
        send_request(write, addr, data);
        if (remote)
            serve_remote(write, addr, data);
        if (write) begin
            finish_write(!remote);
            if (!remote) begin
                if (!local_valid[addr[10:0]])
                    written_q.push_back(addr[10:0]);
                local_valid[addr[10:0]] = 1'b1;
                local_model[addr[10:0]] = data;
            end
        end else begin
            collect_read(!remote, got);
            if (remote)
                check(32'(got), 32'(remote_model[addr[10:0]]), "remote read data");
            else
                check(32'(got), 32'(local_model[addr[10:0]]), "local read data");
        end
    endtask

    initial begin
        bridge_pkg::addr_t a;
        bridge_pkg::data_t d;
        logic              w;
        int                n, k;
        clk    = 1'b0;
        rstn   = 1'b0;
        swdata = 1'b0;
        smode  = 1'b0;
        mvalid = 1'b0;
        u_rx   = 1'b1;  // Remote line idles high
        errors = 0;
        checks = 0;
        cycles = 0;
        void'($urandom(32'h2737));
        for (k = 0; k < 2048; k++) begin
            local_valid[k]  = 1'b0;
            local_model[k]  = 8'h00;
            remote_model[k] = 8'(k) ^ 8'(k >> 3);  // Depends on all 11 bits
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check(32'(sready), 32'd1, "sready after reset");
        check(32'(svalid), 32'd0, "svalid after reset");
        check(32'(srdata), 32'd0, "srdata after reset");
        check(32'(u_tx), 32'd1, "u_tx after reset");

        // Directed local and remote accesses
        do_transaction(1'b1, 12'h123, 8'h5a);
        do_transaction(1'b0, 12'h123, 8'h00);
        do_transaction(1'b1, 12'h9a5, 8'hc3);
        do_transaction(1'b0, 12'h9a5, 8'h00);
        do_transaction(1'b0, 12'hf0f, 8'h00);  // Remote word never written

        // Random mix
        for (n = 0; n < N_RANDOM; n++) begin
            w = 1'($urandom_range(1, 0));
            a = 12'($urandom);
            d = 8'($urandom);
            if (!w && !a[11]) begin
                if (written_q.size() == 0)
                    w = 1'b1;  // Nothing local to read yet
                else
                    a = {1'b0, written_q[$urandom_range(written_q.size() - 1, 0)]};
            end
            repeat ($urandom_range(7, 0)) @(negedge clk);
            do_transaction(w, a, d);
        end

        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb.f
bridge_pkg.sv
serial_slave_port.sv
local_mem.sv
uart_tx.sv
uart_rx.sv
bridge_ctrl.sv
bus_bridge_slave.sv
tb_bus_bridge_slave.sv

//--- run.sh
#!/bin/bash
# Build and run the bus bridge slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_bus_bridge_slave -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
